// ==== dump_geom_pkg.sv ====
`default_nettype none

package dump_geom_pkg;

    localparam int BUF_BIT_ADDR_W  = 13;   // 8 Kbit buffer
    localparam int BUF_BYTE_ADDR_W = 10;   // 1 Kbyte view of the same memory

    typedef logic [BUF_BIT_ADDR_W-1:0]  buf_bit_addr_t;
    typedef logic [BUF_BYTE_ADDR_W-1:0] buf_byte_addr_t;

    // a buffer byte is printed nibble by nibble
    typedef union packed {
        logic [7:0] whole;
        struct packed {
            logic [3:0] hi;
            logic [3:0] lo;
        } nib;
    } dump_byte_t;

    typedef logic [11:0] page_t;           // relative page number

endpackage

`default_nettype wire

// ==== dump_text_pkg.sv ====
`default_nettype none

package dump_text_pkg;

    localparam int TEXT_ADDR_W = 7;

    typedef logic [TEXT_ADDR_W-1:0] text_addr_t;
    typedef logic [7:0]             char_t;

    localparam char_t CHAR_SPACE    = 8'h20;
    localparam char_t CHAR_LINE_END = 8'h0D;   // carriage return

    // rom layout
    localparam text_addr_t HEX_DIGIT_BASE = 7'h00;   // "0".."9","A".."F"
    localparam text_addr_t BOOT_MSG_ADDR  = 7'h10;
    localparam text_addr_t USER_MSG_ADDR  = 7'h50;

    localparam int BOOT_MSG_LEN = 16;
    localparam int USER_MSG_LEN = 10;

    // first character sits in the top byte
    localparam logic [8*BOOT_MSG_LEN-1:0] BOOT_MSG = "BOOT LOADER DUMP";
    localparam logic [8*USER_MSG_LEN-1:0] USER_MSG = "USER PAGE ";

endpackage

`default_nettype wire

// ==== byte_stream_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface byte_stream_if import dump_text_pkg::*; ();

    char_t tx_char;   // stable from send until done
    logic  send;      // one-cycle request
    logic  cancel;    // abort, no done follows
    logic  done;      // one-cycle completion

    modport seq    (output tx_char, send, cancel, input done);
    modport writer (input tx_char, send, cancel, output done);

endinterface

`default_nettype wire

// ==== sipo_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sipo_buffer import dump_geom_pkg::*; (
    input  wire logic           MCLK,
    input  wire logic           wr_en_n,
    input  wire buf_bit_addr_t  wr_addr,
    input  wire logic           wr_bit,
    input  wire logic           rd_en,
    input  wire buf_byte_addr_t rd_addr,
    output dump_byte_t          rd_data
);

    localparam int DEPTH = 1 << BUF_BYTE_ADDR_W;

    dump_byte_t mem [DEPTH];

    // bit 0 of the address field is the msb of the byte
    always_ff @(posedge MCLK) begin
        if (!wr_en_n) begin
            mem[wr_addr[BUF_BIT_ADDR_W-1:3]].whole[3'd7 - wr_addr[2:0]] <= wr_bit;
        end
    end

    always_ff @(posedge MCLK) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];   // holds while rd_en is low
        end
    end

endmodule

`default_nettype wire

// ==== text_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module text_rom import dump_text_pkg::*; (
    input  wire logic       MCLK,
    input  wire logic       rd_en,
    input  wire text_addr_t addr,
    output char_t           data
);

    localparam int DEPTH = 1 << TEXT_ADDR_W;

    function automatic char_t rom_entry(int a);
        int    d;
        char_t c;
        d = a - int'(HEX_DIGIT_BASE);
        c = CHAR_SPACE;   // unused slots
        if (d >= 0 && d < 10) begin
            c = char_t'(8'h30 + d);
        end else if (d >= 10 && d < 16) begin
            c = char_t'(8'h41 + d - 10);
        end else if (a >= BOOT_MSG_ADDR && a < int'(BOOT_MSG_ADDR) + BOOT_MSG_LEN) begin
            c = BOOT_MSG[8*(BOOT_MSG_LEN - 1 - (a - BOOT_MSG_ADDR)) +: 8];
        end else if (a >= USER_MSG_ADDR && a < int'(USER_MSG_ADDR) + USER_MSG_LEN) begin
            c = USER_MSG[8*(USER_MSG_LEN - 1 - (a - USER_MSG_ADDR)) +: 8];
        end
        return c;
    endfunction

    char_t table_w [DEPTH];

    for (genvar i = 0; i < DEPTH; i++) begin : g_fill
        assign table_w[i] = rom_entry(i);
    end

    always_ff @(posedge MCLK) begin
        if (rd_en) begin
            data <= table_w[addr];
        end
    end

endmodule

`default_nettype wire

// ==== dump_config.sv ====
`timescale 1ns/1ps
`default_nettype none

module dump_config import dump_geom_pkg::*, dump_text_pkg::*; #(
    parameter int BOOT_LINES = 30,
    parameter int USER_LINES = 8
) (
    input  wire logic  MCLK,
    input  wire logic  arst_n,
    input  wire logic  start,
    input  wire logic  send_boot_n,
    input  wire page_t rel_page,
    output logic       job_boot,
    output text_addr_t msg_addr,
    output logic [7:0] msg_len,
    output logic [7:0] line_count,
    output page_t      page
);

    always_ff @(posedge MCLK or negedge arst_n) begin
        if (!arst_n) begin
            job_boot <= 1'b0;
        end else if (start) begin
            job_boot <= !send_boot_n;   // boot wins over user
        end
    end

    always_ff @(posedge MCLK) begin
        if (start) begin
            page <= rel_page;
        end
    end

    assign msg_addr   = job_boot ? BOOT_MSG_ADDR : USER_MSG_ADDR;
    assign msg_len    = job_boot ? 8'(BOOT_MSG_LEN) : 8'(USER_MSG_LEN);
    assign line_count = job_boot ? 8'(BOOT_LINES) : 8'(USER_LINES);

endmodule

`default_nettype wire

// ==== dump_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dump_sequencer import dump_geom_pkg::*, dump_text_pkg::*; #(
    parameter int BYTES_PER_LINE = 16
) (
    input  wire logic       MCLK,
    input  wire logic       arst_n,
    input  wire logic       fifo_en_n,
    input  wire logic       send_boot_n,
    input  wire logic       send_user_n,
    input  wire logic       job_boot,
    input  wire text_addr_t msg_addr,
    input  wire logic [7:0] msg_len,
    input  wire logic [7:0] line_count,
    input  wire page_t      page,
    input  wire char_t      rom_data,
    input  wire dump_byte_t buf_data,
    output logic            start,
    output logic            rom_en,
    output text_addr_t      rom_addr,
    output logic            buf_en,
    output buf_byte_addr_t  buf_addr,
    byte_stream_if.seq      bs
);

    typedef enum logic [4:0] {
        S_READY, S_LOAD, S_MSG, S_MSG_RD, S_MSG_SEND,
        S_PG_RD, S_PG_SEND, S_PG_END,
        S_LINE, S_BYTE, S_BUF_RD, S_HI_RD, S_HI_SEND, S_LO_RD, S_LO_SEND,
        S_SPACE, S_EOL, S_FINAL, S_TX, S_DONE
    } state_t;

    state_t         state, ret_state;
    logic [7:0]     cnt;        // message chars, then bytes left in the line
    logic [7:0]     line_cnt;
    logic [1:0]     dig;        // page digit index counting from the msd
    text_addr_t     txt_ptr;
    buf_byte_addr_t buf_ptr;
    dump_byte_t     cur_byte;
    logic [3:0]     page_nib;
    logic           released;

    assign released = send_boot_n && send_user_n;
    assign start    = (state == S_READY) && !fifo_en_n && !released;

    always_comb begin
        case (dig)
            2'd0:    page_nib = page[11:8];
            2'd1:    page_nib = page[7:4];
            default: page_nib = page[3:0];
        endcase
    end

    // read ports decoded from state with data valid in the following state
    always_comb begin
        rom_en   = 1'b0;
        rom_addr = txt_ptr;
        case (state)
            S_MSG_RD: rom_en = 1'b1;
            S_PG_RD: begin
                rom_en   = 1'b1;
                rom_addr = HEX_DIGIT_BASE + {3'b000, page_nib};
            end
            S_HI_RD: begin
                rom_en   = 1'b1;
                rom_addr = HEX_DIGIT_BASE + {3'b000, buf_data.nib.hi};
            end
            S_LO_RD: begin
                rom_en   = 1'b1;
                rom_addr = HEX_DIGIT_BASE + {3'b000, cur_byte.nib.lo};
            end
            default: ;
        endcase
    end

    assign buf_en   = (state == S_BUF_RD);
    assign buf_addr = buf_ptr;

    always_ff @(posedge MCLK or negedge arst_n) begin
        if (!arst_n) begin
            state     <= S_READY;
            ret_state <= S_READY;
            cnt       <= '0;
            line_cnt  <= '0;
            dig       <= '0;
            txt_ptr   <= '0;
            buf_ptr   <= '0;
            bs.send   <= 1'b0;
            bs.cancel <= 1'b0;
        end else begin
            bs.send   <= 1'b0;
            bs.cancel <= 1'b0;
            case (state)
                S_READY:    if (start) state <= S_LOAD;
                S_LOAD: begin                       // config is valid from here
                    cnt      <= msg_len;
                    txt_ptr  <= msg_addr;
                    line_cnt <= line_count;
                    buf_ptr  <= '0;
                    dig      <= '0;
                    state    <= S_MSG;
                end
                S_MSG:      state <= (cnt == 8'd0) ? (job_boot ? S_LINE : S_PG_RD) : S_MSG_RD;
                S_MSG_RD:   state <= S_MSG_SEND;
                S_MSG_SEND: begin
                    txt_ptr   <= txt_ptr + 1'b1;
                    cnt       <= cnt - 8'd1;
                    bs.send   <= 1'b1;
                    ret_state <= S_MSG;
                    state     <= S_TX;
                end
                S_PG_RD:    state <= S_PG_SEND;
                S_PG_SEND: begin
                    dig       <= dig + 2'd1;
                    bs.send   <= 1'b1;
                    ret_state <= (dig == 2'd2) ? S_PG_END : S_PG_RD;
                    state     <= S_TX;
                end
                S_PG_END, S_EOL: begin
                    if (state == S_EOL) line_cnt <= line_cnt - 8'd1;
                    bs.send   <= 1'b1;
                    ret_state <= S_LINE;
                    state     <= S_TX;
                end
                S_LINE: begin
                    cnt   <= 8'(BYTES_PER_LINE);
                    state <= (line_cnt == 8'd0) ? S_FINAL : S_BYTE;
                end
                S_BYTE:     state <= (cnt == 8'd0) ? S_EOL : S_BUF_RD;
                S_BUF_RD:   state <= S_HI_RD;
                S_HI_RD:    state <= S_HI_SEND;
                S_HI_SEND: begin
                    bs.send   <= 1'b1;
                    ret_state <= S_LO_RD;
                    state     <= S_TX;
                end
                S_LO_RD:    state <= S_LO_SEND;
                S_LO_SEND: begin
                    bs.send   <= 1'b1;
                    ret_state <= S_SPACE;
                    state     <= S_TX;
                end
                S_SPACE: begin
                    buf_ptr   <= buf_ptr + 1'b1;
                    cnt       <= cnt - 8'd1;
                    bs.send   <= 1'b1;
                    ret_state <= S_BYTE;
                    state     <= S_TX;
                end
                S_FINAL: begin
                    bs.send   <= 1'b1;
                    ret_state <= S_DONE;
                    state     <= S_TX;
                end
                S_TX: begin                         // character pending at the writer
                    if (released) begin
                        bs.cancel <= 1'b1;
                        state     <= S_READY;
                    end else if (bs.done) begin
                        state <= ret_state;
                    end
                end
                S_DONE:     if (released) state <= S_READY;
                default:    state <= S_READY;
            endcase
        end
    end

    always_ff @(posedge MCLK) begin
        if (state == S_HI_RD) cur_byte <= buf_data;   // keep the lo nibble
        case (state)
            S_MSG_SEND, S_PG_SEND, S_HI_SEND, S_LO_SEND: bs.tx_char <= rom_data;
            S_SPACE:                   bs.tx_char <= CHAR_SPACE;
            S_PG_END, S_EOL, S_FINAL:  bs.tx_char <= CHAR_LINE_END;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== fifo_byte_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_byte_writer import dump_text_pkg::*; (
    input  wire logic     MCLK,
    input  wire logic     arst_n,
    input  wire logic     txe_n,
    byte_stream_if.writer bs,
    output logic          wr_n,
    output char_t         data
);

    typedef enum logic [1:0] {W_IDLE, W_WAIT_TXE, W_STROBE, W_HOLD} wstate_t;

    wstate_t state;

    always_ff @(posedge MCLK or negedge arst_n) begin
        if (!arst_n) begin
            state   <= W_IDLE;
            wr_n    <= 1'b1;
            bs.done <= 1'b0;
        end else begin
            bs.done <= 1'b0;
            if (bs.cancel) begin
                state <= W_IDLE;
                wr_n  <= 1'b1;
            end else begin
                case (state)
                    W_IDLE:     if (bs.send) state <= W_WAIT_TXE;
                    W_WAIT_TXE: begin
                        if (!txe_n) begin        // bridge has room
                            wr_n  <= 1'b0;
                            state <= W_STROBE;
                        end
                    end
                    W_STROBE:   state <= W_HOLD;  // second low cycle
                    W_HOLD: begin
                        wr_n    <= 1'b1;
                        bs.done <= 1'b1;
                        state   <= W_IDLE;
                    end
                    default:    state <= W_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge MCLK) begin
        if (state == W_IDLE && bs.send) begin
            data <= bs.tx_char;
        end
    end

endmodule

`default_nettype wire

// ==== ft_pin_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module ft_pin_mux import dump_text_pkg::*; (
    input  wire logic  fifo_en_n,
    input  wire logic  mpsse_en_n,
    input  wire logic  wr_n_int,
    input  wire char_t data_int,
    input  wire logic  host_mpsse_clk,
    input  wire logic  host_mpsse_mosi,
    input  wire logic  host_mpsse_cs_n,
    input  wire logic  flash_miso,
    output char_t      ad_out,
    output logic       ad_oe,
    output logic       wr_n,
    output logic       flash_clk,
    output logic       flash_mosi,
    output logic       flash_cs_n,
    output logic       host_mpsse_miso
);

    // fifo side
    assign ad_oe  = !fifo_en_n;
    assign ad_out = fifo_en_n ? 8'h00 : data_int;
    assign wr_n   = fifo_en_n ? 1'b1 : wr_n_int;

    // flash stays deselected unless mpsse mode is on
    assign flash_clk       = mpsse_en_n ? 1'b1 : host_mpsse_clk;
    assign flash_mosi      = mpsse_en_n ? 1'b0 : host_mpsse_mosi;
    assign flash_cs_n      = mpsse_en_n ? 1'b1 : host_mpsse_cs_n;
    assign host_mpsse_miso = mpsse_en_n ? 1'b0 : flash_miso;

endmodule

`default_nettype wire

// ==== usb_dump_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module usb_dump_top import dump_geom_pkg::*, dump_text_pkg::*; #(
    parameter int BOOT_LINES     = 30,
    parameter int USER_LINES     = 8,
    parameter int BYTES_PER_LINE = 16
) (
    input  wire logic          MCLK,
    input  wire logic          arst_n,
    input  wire logic          fifo_en_n,
    input  wire logic          mpsse_en_n,
    input  wire logic          buf_wr_en_n,
    input  wire buf_bit_addr_t buf_wr_addr,
    input  wire logic          buf_wr_data,
    input  wire logic          send_boot_n,
    input  wire logic          send_user_n,
    input  wire page_t         rel_page,
    input  wire logic          txe_n,
    output char_t              ad_out,
    output logic               ad_oe,
    output logic               wr_n,
    input  wire logic          host_mpsse_clk,
    input  wire logic          host_mpsse_mosi,
    input  wire logic          host_mpsse_cs_n,
    output logic               host_mpsse_miso,
    output logic               flash_clk,
    output logic               flash_mosi,
    output logic               flash_cs_n,
    input  wire logic          flash_miso
);

    logic           start, job_boot, rom_en, buf_en, wr_n_int;
    text_addr_t     msg_addr, rom_addr;
    logic [7:0]     msg_len, line_count;
    page_t          page;
    char_t          rom_data, data_int;
    buf_byte_addr_t buf_addr;
    dump_byte_t     buf_data;

    byte_stream_if bs ();

    sipo_buffer u_buf (
        .MCLK(MCLK), .wr_en_n(buf_wr_en_n), .wr_addr(buf_wr_addr), .wr_bit(buf_wr_data),
        .rd_en(buf_en), .rd_addr(buf_addr), .rd_data(buf_data)
    );

    text_rom u_rom (.MCLK(MCLK), .rd_en(rom_en), .addr(rom_addr), .data(rom_data));

    dump_config #(.BOOT_LINES(BOOT_LINES), .USER_LINES(USER_LINES)) u_cfg (
        .MCLK(MCLK), .arst_n(arst_n), .start(start), .send_boot_n(send_boot_n),
        .rel_page(rel_page), .job_boot(job_boot), .msg_addr(msg_addr),
        .msg_len(msg_len), .line_count(line_count), .page(page)
    );

    dump_sequencer #(.BYTES_PER_LINE(BYTES_PER_LINE)) u_seq (
        .MCLK(MCLK), .arst_n(arst_n), .fifo_en_n(fifo_en_n),
        .send_boot_n(send_boot_n), .send_user_n(send_user_n),
        .job_boot(job_boot), .msg_addr(msg_addr), .msg_len(msg_len),
        .line_count(line_count), .page(page), .rom_data(rom_data), .buf_data(buf_data),
        .start(start), .rom_en(rom_en), .rom_addr(rom_addr),
        .buf_en(buf_en), .buf_addr(buf_addr), .bs(bs.seq)
    );

    fifo_byte_writer u_wr (
        .MCLK(MCLK), .arst_n(arst_n), .txe_n(txe_n), .bs(bs.writer),
        .wr_n(wr_n_int), .data(data_int)
    );

    ft_pin_mux u_mux (
        .fifo_en_n(fifo_en_n), .mpsse_en_n(mpsse_en_n), .wr_n_int(wr_n_int),
        .data_int(data_int), .host_mpsse_clk(host_mpsse_clk),
        .host_mpsse_mosi(host_mpsse_mosi), .host_mpsse_cs_n(host_mpsse_cs_n),
        .flash_miso(flash_miso), .ad_out(ad_out), .ad_oe(ad_oe), .wr_n(wr_n),
        .flash_clk(flash_clk), .flash_mosi(flash_mosi), .flash_cs_n(flash_cs_n),
        .host_mpsse_miso(host_mpsse_miso)
    );

endmodule

`default_nettype wire

// ==== tb_dump_ref.svh ====
`ifndef TB_DUMP_REF_SVH
`define TB_DUMP_REF_SVH

// included inside tb_usb_dump, which provides char_q_t, buf_copy and the line parameters

// upper-case hex digit for one nibble
function automatic char_t hex_char(input logic [3:0] n);
    if (n < 4'd10) begin
        return char_t'(8'h30 + {4'h0, n});   // "0".."9"
    end
    return char_t'(8'h41 + {4'h0, n} - 8'd10);   // "A".."F"
endfunction

// full character stream of one dump in the order the bridge should see it
function automatic char_q_t ref_stream(input logic boot, input page_t pg);
    char_q_t s;
    int      n_lines;
    int      addr;
    if (boot) begin
        for (int i = 0; i < BOOT_MSG_LEN; i++) begin
            s.push_back(BOOT_MSG[8*(BOOT_MSG_LEN-1-i) +: 8]);   // first char in top byte
        end
        n_lines = BOOT_LINES;
    end else begin
        for (int i = 0; i < USER_MSG_LEN; i++) begin
            s.push_back(USER_MSG[8*(USER_MSG_LEN-1-i) +: 8]);
        end
        s.push_back(hex_char(pg[11:8]));
        s.push_back(hex_char(pg[7:4]));
        s.push_back(hex_char(pg[3:0]));
        s.push_back(CHAR_LINE_END);
        n_lines = USER_LINES;
    end
    addr = 0;
    for (int l = 0; l < n_lines; l++) begin
        for (int b = 0; b < BYTES_PER_LINE; b++) begin
            s.push_back(hex_char(buf_copy[addr][7:4]));
            s.push_back(hex_char(buf_copy[addr][3:0]));
            s.push_back(CHAR_SPACE);
            addr++;
        end
        s.push_back(CHAR_LINE_END);
    end
    s.push_back(CHAR_LINE_END);   // closing line end
    return s;
endfunction

`endif

// ==== tb_usb_dump.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_usb_dump import dump_geom_pkg::*, dump_text_pkg::*; ();

    localparam int BOOT_LINES     = 30;
    localparam int USER_LINES     = 8;
    localparam int BYTES_PER_LINE = 16;

    localparam int LINE_CHARS   = 3 * BYTES_PER_LINE + 1;
    localparam int BOOT_CHARS   = BOOT_MSG_LEN + BOOT_LINES * LINE_CHARS + 1;
    localparam int USER_CHARS   = USER_MSG_LEN + 4 + USER_LINES * LINE_CHARS + 1;
    localparam int MAX_LINES    = (BOOT_LINES > USER_LINES) ? BOOT_LINES : USER_LINES;
    localparam int LOAD_BYTES   = MAX_LINES * BYTES_PER_LINE;
    localparam int RAND_WRITES  = 256;
    localparam int SETUP_CYCLES = 16 + 8 * LOAD_BYTES + RAND_WRITES + 400;
    // three boot dumps (one cancelled) and one user dump
    localparam longint WATCHDOG_NS =
        (longint'(3 * BOOT_CHARS + USER_CHARS) * 40 + SETUP_CYCLES) * 20;

    typedef char_t char_q_t [$];

    logic          MCLK            = 1'b0;
    logic          arst_n          = 1'b0;
    logic          fifo_en_n       = 1'b1;
    logic          mpsse_en_n      = 1'b1;
    logic          buf_wr_en_n     = 1'b1;
    buf_bit_addr_t buf_wr_addr     = '0;
    logic          buf_wr_data     = 1'b0;
    logic          send_boot_n     = 1'b1;
    logic          send_user_n     = 1'b1;
    page_t         rel_page        = '0;
    logic          txe_n           = 1'b1;
    logic          host_mpsse_clk  = 1'b0;
    logic          host_mpsse_mosi = 1'b1;
    logic          host_mpsse_cs_n = 1'b0;
    logic          flash_miso      = 1'b0;

    char_t ad_out;
    logic  ad_oe, wr_n, host_mpsse_miso, flash_clk, flash_mosi, flash_cs_n;

    logic [7:0] buf_copy [1 << BUF_BYTE_ADDR_W];   // what the buffer should hold
    char_q_t    exp_q;
    int         n_checked = 0;
    logic [1:0] gap_tab [256];                      // txe_n high time after each write
    logic [7:0] gap_idx   = '0;
    logic [1:0] txe_wait  = '0;
    logic       stall     = 1'b0;                   // bridge reports full while set
    logic       wr_n_d    = 1'b1;
    logic       txe_d     = 1'b1;

    `include "tb_dump_ref.svh"

    usb_dump_top #(
        .BOOT_LINES(BOOT_LINES), .USER_LINES(USER_LINES), .BYTES_PER_LINE(BYTES_PER_LINE)
    ) DUT (
        .MCLK(MCLK), .arst_n(arst_n), .fifo_en_n(fifo_en_n), .mpsse_en_n(mpsse_en_n),
        .buf_wr_en_n(buf_wr_en_n), .buf_wr_addr(buf_wr_addr), .buf_wr_data(buf_wr_data),
        .send_boot_n(send_boot_n), .send_user_n(send_user_n), .rel_page(rel_page),
        .txe_n(txe_n), .ad_out(ad_out), .ad_oe(ad_oe), .wr_n(wr_n),
        .host_mpsse_clk(host_mpsse_clk), .host_mpsse_mosi(host_mpsse_mosi),
        .host_mpsse_cs_n(host_mpsse_cs_n), .host_mpsse_miso(host_mpsse_miso),
        .flash_clk(flash_clk), .flash_mosi(flash_mosi), .flash_cs_n(flash_cs_n),
        .flash_miso(flash_miso)
    );

    always #10 MCLK = ~MCLK;

    task automatic stop_on_failure();
        $display("Something failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_char(input char_t got, input char_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s is %02h, expected %02h", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    // bridge model drives txe_n high for a few cycles after each write
    always @(posedge MCLK) begin : bridge_model
        if (stall) begin
            txe_n    <= 1'b1;
            txe_wait <= '0;
        end else if (!wr_n_d && wr_n) begin       // a write just ended
            txe_n    <= (gap_tab[gap_idx] != 2'd0);
            txe_wait <= gap_tab[gap_idx];
            gap_idx  <= gap_idx + 8'd1;
        end else if (txe_wait != 2'd0) begin
            txe_n    <= (txe_wait > 2'd1);
            txe_wait <= txe_wait - 2'd1;
        end else begin
            txe_n <= 1'b0;
        end
    end

    // capture each character on the falling edge of wr_n and compare it
    always @(posedge MCLK) begin : capture_compare
        wr_n_d <= wr_n;
        txe_d  <= txe_n;
        if (arst_n && wr_n_d && !wr_n) begin
            check_bit(txe_d, 1'b0, "txe_n before the falling edge of wr_n");
            if (n_checked >= exp_q.size()) begin
                $display("the DUT wrote character %02h at time %0t when no dump was active",
                         ad_out, $time);
                stop_on_failure();
            end else begin
                check_char(ad_out, exp_q[n_checked], $sformatf("character %0d", n_checked));
                n_checked <= n_checked + 1;
            end
        end
    end

    task automatic check_mpsse_pins();
        logic [3:0] r;
        @(posedge MCLK);
        check_bit(flash_clk, 1'b1, "idle flash_clk");
        check_bit(flash_mosi, 1'b0, "idle flash_mosi");
        check_bit(flash_cs_n, 1'b1, "idle flash_cs_n");
        mpsse_en_n <= 1'b0;
        for (int i = 0; i < 16; i++) begin
            r = 4'($urandom);
            host_mpsse_clk  <= r[0];
            host_mpsse_mosi <= r[1];
            host_mpsse_cs_n <= r[2];
            flash_miso      <= r[3];
            @(posedge MCLK);
            check_bit(flash_clk, r[0], "flash_clk in mpsse mode");
            check_bit(flash_mosi, r[1], "flash_mosi in mpsse mode");
            check_bit(flash_cs_n, r[2], "flash_cs_n in mpsse mode");
            check_bit(host_mpsse_miso, r[3], "host_mpsse_miso in mpsse mode");
        end
        mpsse_en_n      <= 1'b1;
        host_mpsse_clk  <= 1'b0;                   // host pins opposite to the idle levels
        host_mpsse_mosi <= 1'b1;
        host_mpsse_cs_n <= 1'b0;
        @(posedge MCLK);
        check_bit(flash_clk, 1'b1, "flash_clk after mpsse mode");
        check_bit(flash_mosi, 1'b0, "flash_mosi after mpsse mode");
        check_bit(flash_cs_n, 1'b1, "flash_cs_n after mpsse mode");
    endtask

    task automatic fill_buffer();
        logic          v;
        buf_bit_addr_t a;
        for (int i = 0; i < 8 * LOAD_BYTES + RAND_WRITES; i++) begin
            if (i < 8 * LOAD_BYTES) begin
                a = buf_bit_addr_t'(i);
            end else begin
                a = buf_bit_addr_t'($urandom % (8 * LOAD_BYTES));   // overwrite some bits
            end
            v = 1'($urandom);
            buf_wr_en_n <= 1'b0;
            buf_wr_addr <= a;
            buf_wr_data <= v;
            buf_copy[a[BUF_BIT_ADDR_W-1:3]][3'd7 - a[2:0]] = v;   // bit 0 is the msb
            @(posedge MCLK);
        end
        buf_wr_en_n <= 1'b1;
        @(posedge MCLK);
    endtask

    task automatic run_dump(input logic boot, input page_t pg);
        char_q_t s;
        s = ref_stream(boot, pg);
        foreach (s[k]) exp_q.push_back(s[k]);
        rel_page    <= pg;
        send_boot_n <= !boot;
        send_user_n <= boot;
        while (n_checked < exp_q.size()) @(posedge MCLK);
        repeat (8) @(posedge MCLK);                 // nothing more may follow
        send_boot_n <= 1'b1;
        send_user_n <= 1'b1;
        repeat (8) @(posedge MCLK);
    endtask

    task automatic cancel_dump();
        char_q_t s;
        int      stop_at;
        s = ref_stream(1'b1, '0);
        foreach (s[k]) exp_q.push_back(s[k]);
        stop_at     = n_checked + BOOT_CHARS / 3;
        send_boot_n <= 1'b0;
        while (n_checked < stop_at) @(posedge MCLK);
        stall <= 1'b1;
        repeat (10) @(posedge MCLK);               // writer now waits on txe_n
        send_boot_n <= 1'b1;
        repeat (20) @(posedge MCLK);
        while (exp_q.size() > n_checked) exp_q.pop_back();   // never sent
        stall <= 1'b0;
        repeat (100) @(posedge MCLK);
    endtask

    initial begin : main_seq
        void'($urandom(32'h8d57_b1fd));
        foreach (gap_tab[i]) gap_tab[i] = 2'($urandom % 4);
        repeat (16) @(posedge MCLK);
        arst_n <= 1'b1;
        @(posedge MCLK);
        check_bit(wr_n, 1'b1, "wr_n after reset");
        check_bit(ad_oe, 1'b0, "ad_oe after reset");
        check_mpsse_pins();
        fill_buffer();
        fifo_en_n <= 1'b0;
        @(posedge MCLK);
        check_bit(ad_oe, 1'b1, "ad_oe in fifo mode");
        check_bit(wr_n, 1'b1, "wr_n in fifo mode before a dump");
        run_dump(1'b1, '0);
        run_dump(1'b0, page_t'($urandom));
        cancel_dump();
        run_dump(1'b1, page_t'($urandom));
        if (n_checked == exp_q.size()) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("only %0d of %0d characters were written", n_checked, exp_q.size());
            stop_on_failure();
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout, the dumps did not complete within %0d ns", WATCHDOG_NS);
        stop_on_failure();
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
dump_geom_pkg.sv
dump_text_pkg.sv
byte_stream_if.sv
sipo_buffer.sv
text_rom.sv
dump_config.sv
dump_sequencer.sv
fifo_byte_writer.sv
ft_pin_mux.sv
usb_dump_top.sv
tb_usb_dump.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_usb_dump -f all.f -o tb_usb_dump
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_usb_dump 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1
